// File: filelist.f
+incdir+src
+incdir+verification
src/l2_tag_pkg.sv
src/tag_bram.sv
src/l2_tagv_array.sv
src/l2_plru.sv
src/l2_tag_ctrl.sv
src/l2_tag_unit.sv
verification/l2_tag_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the L2 tag store testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

rm -f sim.log \
    && verilator --binary -Wno-fatal --top-module l2_tag_tb -f filelist.f \
        -o l2_tag_sim > build.log 2>&1 \
    && ./obj_dir/l2_tag_sim 2>&1 | tee sim.log \
    && grep -qx "Testbench passed" sim.log \
    && echo "PASS" \
    || { echo "FAIL: see build.log and sim.log"; exit 1; }

// File: src/l2_plru.sv
`timescale 1ns/1ps
`include "l2_tag_defs.svh"

module l2_plru (
    input  logic                        clk,
    input  logic [`L2_INDEX_BITS-1:0]   index,
    input  logic [`L2_WAYS-1:0]         valid_vec,
    input  logic                        touch,
    input  logic [`L2_INDEX_BITS-1:0]   touch_index,
    input  logic [`L2_WAY_BITS-1:0]     touch_way,
    input  logic                        fill,
    input  logic [`L2_INDEX_BITS-1:0]   fill_index,
    input  logic [`L2_WAY_BITS-1:0]     fill_way,
    input  logic                        clear,
    input  logic [`L2_INDEX_BITS-1:0]   clear_index,
    output logic [`L2_WAY_BITS-1:0]     victim_way
);

    // Bit 0 is the root, bit 1 picks within ways 0/1, bit 2 within ways 2/3
    logic [2:0] plru_q [`L2_SETS];

    logic [2:0]              cur_bits;
    logic [`L2_WAY_BITS-1:0] tree_way;

    // Point the tree away from the way just used
    function automatic logic [2:0] mru_update(input logic [2:0] bits,
                                              input logic [`L2_WAY_BITS-1:0] way);
        logic [2:0] nxt;
        nxt    = bits;
        nxt[0] = ~way[1];
        if (way[1]) begin
            nxt[2] = ~way[0];
        end else begin
            nxt[1] = ~way[0];
        end
        return nxt;
    endfunction

    ////////////////////////////////////////
    // State update
    ////////////////////////////////////////

    // Later statements win on the same set, so clear > fill > touch
    always_ff @(posedge clk) begin
        if (touch) begin
            plru_q[touch_index] <= mru_update(plru_q[touch_index], touch_way);
        end
        if (fill) begin
            plru_q[fill_index] <= mru_update(plru_q[fill_index], fill_way);
        end
        if (clear) begin
            plru_q[clear_index] <= 3'b000;
        end
    end

    ////////////////////////////////////////
    // Victim choice
    ////////////////////////////////////////

    always_comb begin
        cur_bits = plru_q[index];
        // A fill in this cycle already counts for the victim
        if (fill && (fill_index == index)) begin
            cur_bits = mru_update(cur_bits, fill_way);
        end
        tree_way = cur_bits[0] ? {1'b1, cur_bits[2]} : {1'b0, cur_bits[1]};

        // Lowest invalid way overrides the tree
        victim_way = tree_way;
        for (int i = `L2_WAYS - 1; i >= 0; i--) begin
            if (!valid_vec[i]) begin
                victim_way = i[`L2_WAY_BITS-1:0];
            end
        end
    end

endmodule

// File: src/l2_tag_ctrl.sv
`timescale 1ns/1ps
`include "l2_tag_defs.svh"

module l2_tag_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,
    input  l2_tag_pkg::lookup_req_t             lookup,
    input  l2_tag_pkg::update_req_t             update,
    input  logic [`L2_WAYS-1:0]                 hit_vec,
    input  logic [`L2_WAYS-1:0]                 valid_vec,
    input  logic [`L2_WAYS*`L2_TAG_BITS-1:0]    way_tags,
    input  logic [`L2_WAY_BITS-1:0]             victim_way,
    output logic                                busy,
    output logic [`L2_INDEX_BITS-1:0]           rd_index,
    output logic [`L2_TAG_BITS-1:0]             cmp_tag,
    output l2_tag_pkg::array_wr_t               wr,
    output logic [`L2_INDEX_BITS-1:0]           plru_index,
    output logic                                touch,
    output logic [`L2_INDEX_BITS-1:0]           touch_index,
    output logic [`L2_WAY_BITS-1:0]             touch_way,
    output logic                                fill,
    output logic [`L2_INDEX_BITS-1:0]           fill_index,
    output logic [`L2_WAY_BITS-1:0]             fill_way,
    output logic                                clear,
    output logic [`L2_INDEX_BITS-1:0]           clear_index,
    output l2_tag_pkg::lookup_rsp_t             rsp
);

    l2_tag_pkg::sweep_state_e       state_q;
    logic [`L2_INDEX_BITS-1:0]      sweep_cnt_q;
    logic                           lk_valid_q;
    logic [`L2_INDEX_BITS-1:0]      lk_index_q;
    logic                           hit;
    logic [`L2_WAY_BITS-1:0]        hit_way;
    logic [`L2_WAYS-1:0]            upd_way_oh;

    ////////////////////////////////////////
    // Reset sweep
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= l2_tag_pkg::SWEEP_CLEAR;
            sweep_cnt_q <= '0;
        end else if (state_q == l2_tag_pkg::SWEEP_CLEAR) begin
            sweep_cnt_q <= sweep_cnt_q + 1'b1;
            // Last set is all ones
            if (sweep_cnt_q == {`L2_INDEX_BITS{1'b1}}) begin
                state_q <= l2_tag_pkg::SWEEP_DONE;
            end
        end
    end

    assign busy        = (state_q == l2_tag_pkg::SWEEP_CLEAR);
    assign clear       = busy;
    assign clear_index = sweep_cnt_q;

    ////////////////////////////////////////
    // Update port
    ////////////////////////////////////////

    always_comb begin
        upd_way_oh             = '0;
        upd_way_oh[update.way] = 1'b1;
    end

    always_comb begin
        wr = '0;
        if (busy) begin
            // Wipe every way of the sweep set
            wr.index     = sweep_cnt_q;
            wr.tag_we    = '1;
            wr.clr_valid = '1;
        end else begin
            wr.index = update.index;
            wr.tag   = update.tag;
            case (update.op)
                l2_tag_pkg::UPD_FILL: begin
                    wr.tag_we    = upd_way_oh;
                    wr.set_valid = upd_way_oh;
                end
                l2_tag_pkg::UPD_INVAL: begin
                    wr.clr_valid = upd_way_oh;
                end
                default: ;
            endcase
        end
    end

    assign fill       = !busy && (update.op == l2_tag_pkg::UPD_FILL);
    assign fill_index = update.index;
    assign fill_way   = update.way;

    ////////////////////////////////////////
    // Lookup port
    ////////////////////////////////////////

    assign rd_index = lookup.index;
    assign cmp_tag  = lookup.tag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lk_valid_q <= 1'b0;
        end else begin
            lk_valid_q <= lookup.valid && !busy;
        end
    end

    always_ff @(posedge clk) begin
        lk_index_q <= lookup.index;
    end

    // Hit way encode, lowest way first
    always_comb begin
        hit_way = '0;
        for (int i = `L2_WAYS - 1; i >= 0; i--) begin
            if (hit_vec[i]) begin
                hit_way = i[`L2_WAY_BITS-1:0];
            end
        end
    end

    assign hit        = |hit_vec;
    assign plru_index = lk_index_q;

    // Hit makes its way MRU at the end of the response cycle
    assign touch       = lk_valid_q && hit;
    assign touch_index = lk_index_q;
    assign touch_way   = hit_way;

    always_comb begin
        rsp.valid      = lk_valid_q;
        rsp.hit        = hit;
        rsp.hit_way    = hit_way;
        rsp.hit_vec    = hit_vec;
        rsp.valid_vec  = valid_vec;
        rsp.victim_way = victim_way;
        rsp.victim_tag = way_tags[victim_way*`L2_TAG_BITS +: `L2_TAG_BITS];
    end

endmodule

// File: src/l2_tag_defs.svh
`ifndef L2_TAG_DEFS_SVH
`define L2_TAG_DEFS_SVH

////////////////////////////////////////
// Cache geometry
////////////////////////////////////////

// Set index width
`define L2_INDEX_BITS 4

// Stored tag width
`define L2_TAG_BITS 25

// Associativity
`define L2_WAYS 4
`define L2_WAY_BITS 2

// Derived set count
`define L2_SETS (1 << `L2_INDEX_BITS)

`endif

// File: src/l2_tag_pkg.sv
`include "l2_tag_defs.svh"

package l2_tag_pkg;

    // Update port opcodes
    typedef enum logic [1:0] {
        UPD_NONE  = 2'd0,
        UPD_FILL  = 2'd1,
        UPD_INVAL = 2'd2
    } upd_op_e;

    // Controller state
    typedef enum logic {
        SWEEP_CLEAR = 1'b0,
        SWEEP_DONE  = 1'b1
    } sweep_state_e;

    ////////////////////////////////////////
    // Port bundles
    ////////////////////////////////////////

    typedef struct packed {
        logic                       valid;
        logic [`L2_INDEX_BITS-1:0]  index;
        logic [`L2_TAG_BITS-1:0]    tag;
    } lookup_req_t;

    typedef struct packed {
        upd_op_e                    op;
        logic [`L2_INDEX_BITS-1:0]  index;
        logic [`L2_WAY_BITS-1:0]    way;
        logic [`L2_TAG_BITS-1:0]    tag;
    } update_req_t;

    typedef struct packed {
        logic                       valid;
        logic                       hit;
        logic [`L2_WAY_BITS-1:0]    hit_way;
        logic [`L2_WAYS-1:0]        hit_vec;
        logic [`L2_WAYS-1:0]        valid_vec;
        logic [`L2_WAY_BITS-1:0]    victim_way;
        logic [`L2_TAG_BITS-1:0]    victim_tag;
    } lookup_rsp_t;

    // Write command into the tag/valid array, one mask bit per way
    typedef struct packed {
        logic [`L2_INDEX_BITS-1:0]  index;
        logic [`L2_WAYS-1:0]        tag_we;
        logic [`L2_WAYS-1:0]        set_valid;
        logic [`L2_WAYS-1:0]        clr_valid;
        logic [`L2_TAG_BITS-1:0]    tag;
    } array_wr_t;

endpackage

// File: src/l2_tag_unit.sv
`timescale 1ns/1ps
`include "l2_tag_defs.svh"

module l2_tag_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  l2_tag_pkg::lookup_req_t  lookup,
    input  l2_tag_pkg::update_req_t  update,
    output logic                     busy,
    output l2_tag_pkg::lookup_rsp_t  rsp
);

    // Array side
    logic [`L2_INDEX_BITS-1:0]          rd_index;
    logic [`L2_TAG_BITS-1:0]            cmp_tag;
    l2_tag_pkg::array_wr_t              wr;
    logic [`L2_WAYS-1:0]                hit_vec;
    logic [`L2_WAYS-1:0]                valid_vec;
    logic [`L2_WAYS*`L2_TAG_BITS-1:0]   way_tags;

    // Replacement side
    logic [`L2_INDEX_BITS-1:0]          plru_index;
    logic [`L2_WAY_BITS-1:0]            victim_way;
    logic                               touch;
    logic [`L2_INDEX_BITS-1:0]          touch_index;
    logic [`L2_WAY_BITS-1:0]            touch_way;
    logic                               fill;
    logic [`L2_INDEX_BITS-1:0]          fill_index;
    logic [`L2_WAY_BITS-1:0]            fill_way;
    logic                               clear;
    logic [`L2_INDEX_BITS-1:0]          clear_index;

    l2_tag_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup      (lookup),
        .update      (update),
        .hit_vec     (hit_vec),
        .valid_vec   (valid_vec),
        .way_tags    (way_tags),
        .victim_way  (victim_way),
        .busy        (busy),
        .rd_index    (rd_index),
        .cmp_tag     (cmp_tag),
        .wr          (wr),
        .plru_index  (plru_index),
        .touch       (touch),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .fill        (fill),
        .fill_index  (fill_index),
        .fill_way    (fill_way),
        .clear       (clear),
        .clear_index (clear_index),
        .rsp         (rsp)
    );

    l2_tagv_array u_array (
        .clk       (clk),
        .rd_index  (rd_index),
        .cmp_tag   (cmp_tag),
        .wr        (wr),
        .hit_vec   (hit_vec),
        .valid_vec (valid_vec),
        .way_tags  (way_tags)
    );

    l2_plru u_plru (
        .clk         (clk),
        .index       (plru_index),
        .valid_vec   (valid_vec),
        .touch       (touch),
        .touch_index (touch_index),
        .touch_way   (touch_way),
        .fill        (fill),
        .fill_index  (fill_index),
        .fill_way    (fill_way),
        .clear       (clear),
        .clear_index (clear_index),
        .victim_way  (victim_way)
    );

endmodule

// File: src/l2_tagv_array.sv
`timescale 1ns/1ps
`include "l2_tag_defs.svh"

module l2_tagv_array (
    input  logic                                clk,
    input  logic [`L2_INDEX_BITS-1:0]           rd_index,
    input  logic [`L2_TAG_BITS-1:0]             cmp_tag,
    input  l2_tag_pkg::array_wr_t               wr,
    output logic [`L2_WAYS-1:0]                 hit_vec,
    output logic [`L2_WAYS-1:0]                 valid_vec,
    output logic [`L2_WAYS*`L2_TAG_BITS-1:0]    way_tags
);

    // One valid bit per set, per way
    logic [`L2_WAYS-1:0][`L2_SETS-1:0] valid_q;

    // Compare tag lines up with the registered RAM read
    logic [`L2_TAG_BITS-1:0] cmp_tag_q;

    logic [`L2_TAG_BITS-1:0] tag_dout [`L2_WAYS];
    logic                    same_set;

    assign same_set = (wr.index == rd_index);

    ////////////////////////////////////////
    // Valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            // Clear beats set
            if (wr.clr_valid[w]) begin
                valid_q[w][wr.index] <= 1'b0;
            end else if (wr.set_valid[w]) begin
                valid_q[w][wr.index] <= 1'b1;
            end
        end
    end

    // Registered read with forwarding of a same-set write
    always_ff @(posedge clk) begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            if (!same_set) begin
                valid_vec[w] <= valid_q[w][rd_index];
            end else if (wr.clr_valid[w]) begin
                valid_vec[w] <= 1'b0;
            end else if (wr.set_valid[w]) begin
                valid_vec[w] <= 1'b1;
            end else begin
                valid_vec[w] <= valid_q[w][rd_index];
            end
        end
    end

    always_ff @(posedge clk) begin
        cmp_tag_q <= cmp_tag;
    end

    ////////////////////////////////////////
    // Tag RAMs and compare
    ////////////////////////////////////////

    for (genvar w = 0; w < `L2_WAYS; w++) begin : g_way

        tag_bram #(
            .DATA_WIDTH (`L2_TAG_BITS),
            .ADDR_WIDTH (`L2_INDEX_BITS)
        ) u_tag_ram (
            .clk   (clk),
            .waddr (wr.index),
            .din   (wr.tag),
            .we    (wr.tag_we[w]),
            .raddr (rd_index),
            .dout  (tag_dout[w])
        );

        // A way hits only when its valid bit is set
        assign hit_vec[w] = valid_vec[w] && (tag_dout[w] == cmp_tag_q);

        assign way_tags[w*`L2_TAG_BITS +: `L2_TAG_BITS] = tag_dout[w];

    end

endmodule

// File: src/tag_bram.sv
`timescale 1ns/1ps

module tag_bram #(
    parameter int DATA_WIDTH = 25,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] raddr,
    output logic [DATA_WIDTH-1:0] dout
);

    logic [DATA_WIDTH-1:0] mem [(1 << ADDR_WIDTH)];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= din;
        end
        // Write-first on a same-address collision
        if (we && (waddr == raddr)) begin
            dout <= din;
        end else begin
            dout <= mem[raddr];
        end
    end

endmodule

// File: verification/l2_tag_model.svh
`ifndef L2_TAG_MODEL_SVH
`define L2_TAG_MODEL_SVH

////////////////////////////////////////
// Reference state
////////////////////////////////////////

logic [`L2_TAG_BITS-1:0]    model_tag [`L2_SETS][`L2_WAYS];
logic [`L2_WAYS-1:0]        model_valid [`L2_SETS];
// Tree bits: 0 is the root (1 = upper half), 1 covers ways 0/1, 2 covers ways 2/3
logic [2:0]                 model_tree [`L2_SETS];
int                         sweep_left;

// Lookup of the previous cycle, as the array read it
logic                       snap_pending;
logic [`L2_INDEX_BITS-1:0]  snap_index;
logic [`L2_TAG_BITS-1:0]    snap_tag;
logic [`L2_WAYS-1:0]        snap_valid;
logic [`L2_TAG_BITS-1:0]    snap_tags [`L2_WAYS];

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Both tree levels point away from the way just used
function automatic logic [2:0] tree_used(input logic [2:0] bits,
                                         input logic [`L2_WAY_BITS-1:0] way);
    logic [2:0] nxt;
    nxt    = bits;
    nxt[0] = !way[1];
    if (way[1]) begin
        nxt[2] = !way[0];
    end else begin
        nxt[1] = !way[0];
    end
    return nxt;
endfunction

function automatic logic [`L2_WAY_BITS-1:0] tree_victim(input logic [2:0] bits);
    if (bits[0]) begin
        return {1'b1, bits[2]};
    end
    return {1'b0, bits[1]};
endfunction

task automatic model_clear();
    for (int s = 0; s < `L2_SETS; s++) begin
        model_valid[s] = '0;
        model_tree[s]  = 3'b000;
        for (int w = 0; w < `L2_WAYS; w++) begin
            model_tag[s][w] = '0;
        end
    end
    sweep_left   = `L2_SETS;
    snap_pending = 1'b0;
endtask

////////////////////////////////////////
// Expected response and state step
////////////////////////////////////////

// Response to the previous lookup, with a fill of this cycle counted in the tree
function automatic l2_tag_pkg::lookup_rsp_t expected_rsp(input l2_tag_pkg::update_req_t up);
    l2_tag_pkg::lookup_rsp_t r;
    logic [2:0]              bits;
    r           = '0;
    r.valid     = snap_pending;
    r.valid_vec = snap_valid;
    for (int i = 0; i < `L2_WAYS; i++) begin
        r.hit_vec[i] = snap_valid[i] && (snap_tags[i] == snap_tag);
    end
    r.hit = |r.hit_vec;
    for (int i = `L2_WAYS - 1; i >= 0; i--) begin
        if (r.hit_vec[i]) begin
            r.hit_way = i[`L2_WAY_BITS-1:0];
        end
    end
    bits = model_tree[snap_index];
    if (up.op == l2_tag_pkg::UPD_FILL && up.index == snap_index) begin
        bits = tree_used(bits, up.way);
    end
    r.victim_way = tree_victim(bits);
    // Lowest invalid way goes first
    for (int i = `L2_WAYS - 1; i >= 0; i--) begin
        if (!snap_valid[i]) begin
            r.victim_way = i[`L2_WAY_BITS-1:0];
        end
    end
    r.victim_tag = snap_tags[r.victim_way];
    return r;
endfunction

task automatic model_step(input l2_tag_pkg::lookup_req_t lk,
                          input l2_tag_pkg::update_req_t up,
                          input l2_tag_pkg::lookup_rsp_t rsp_exp);
    logic fill_same_set;
    fill_same_set = (up.op == l2_tag_pkg::UPD_FILL) && (up.index == snap_index);
    // A fill to the same set drops the touch of this response
    if (rsp_exp.valid && rsp_exp.hit && !fill_same_set) begin
        model_tree[snap_index] = tree_used(model_tree[snap_index], rsp_exp.hit_way);
    end
    if (up.op == l2_tag_pkg::UPD_FILL) begin
        model_tree[up.index]          = tree_used(model_tree[up.index], up.way);
        model_tag[up.index][up.way]   = up.tag;
        model_valid[up.index][up.way] = 1'b1;
    end else if (up.op == l2_tag_pkg::UPD_INVAL) begin
        model_valid[up.index][up.way] = 1'b0;
    end
    // Lookup of this cycle already sees the update
    snap_pending = lk.valid;
    snap_index   = lk.index;
    snap_tag     = lk.tag;
    snap_valid   = model_valid[lk.index];
    for (int w = 0; w < `L2_WAYS; w++) begin
        snap_tags[w] = model_tag[lk.index][w];
    end
endtask

`endif

// File: verification/l2_tag_tb.sv
`timescale 1ns/1ps
`include "l2_tag_defs.svh"

module l2_tag_tb;

    localparam int CLK_NS       = 20;
    localparam int RAND_OPS     = 400;
    localparam int DIRECTED_OPS = 64;
    // 20 cycles per issued operation plus the sweep and a margin
    localparam int WATCHDOG_NS  = ((RAND_OPS + DIRECTED_OPS) * 20 + `L2_SETS + 100) * CLK_NS;

    localparam logic [`L2_TAG_BITS-1:0] TAG_BASE = 25'h0a5_1c00;
    localparam l2_tag_pkg::lookup_req_t NO_LOOKUP = '0;
    localparam l2_tag_pkg::update_req_t NO_UPDATE = '0;

    logic                    clk = 1'b0;
    logic                    rst_n;
    l2_tag_pkg::lookup_req_t lookup;
    l2_tag_pkg::update_req_t update;
    logic                    busy;
    l2_tag_pkg::lookup_rsp_t rsp;

    int          errors       = 0;
    int          checks       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          test_base    = 0;
    logic [31:0] rnd_state;

    `include "l2_tag_model.svh"

    l2_tag_unit UUT (
        .clk    (clk),
        .rst_n  (rst_n),
        .lookup (lookup),
        .update (update),
        .busy   (busy),
        .rsp    (rsp)
    );

    always #(CLK_NS / 2) clk = ~clk;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic l2_tag_pkg::lookup_req_t make_lookup(
            input logic [`L2_INDEX_BITS-1:0] index, input logic [`L2_TAG_BITS-1:0] tag);
        l2_tag_pkg::lookup_req_t req;
        req.valid = 1'b1;
        req.index = index;
        req.tag   = tag;
        return req;
    endfunction

    function automatic l2_tag_pkg::update_req_t make_update(input l2_tag_pkg::upd_op_e op,
            input logic [`L2_INDEX_BITS-1:0] index, input logic [`L2_WAY_BITS-1:0] way,
            input logic [`L2_TAG_BITS-1:0] tag);
        l2_tag_pkg::update_req_t req;
        req.op    = op;
        req.index = index;
        req.way   = way;
        req.tag   = tag;
        return req;
    endfunction

    // Tags of a small pool share the upper bits
    function automatic logic [`L2_TAG_BITS-1:0] pool_tag(input logic [1:0] sel);
        return {TAG_BASE[`L2_TAG_BITS-1:2], sel};
    endfunction

    task automatic drive(input l2_tag_pkg::lookup_req_t lk, input l2_tag_pkg::update_req_t up);
        @(posedge clk);
        lookup <= lk;
        update <= up;
    endtask

    task automatic report_error(input string field, input logic [31:0] got,
                                input logic [31:0] want);
        $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, field, got, want);
        errors++;
    endtask

    // Two idle cycles let the last response through the compare
    task automatic finish_test(input string name);
        drive(NO_LOOKUP, NO_UPDATE);
        drive(NO_LOOKUP, NO_UPDATE);
        tests_run++;
        if (errors == test_base) begin
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", name, errors - test_base);
        end
        test_base = errors;
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    always @(negedge clk) begin
        l2_tag_pkg::lookup_rsp_t want;
        if (!rst_n || sweep_left > 0) begin
            if (!rst_n) begin
                model_clear();
            end else begin
                sweep_left--;
            end
            if (busy !== 1'b1) begin
                report_error("busy", busy, 1);
            end
            if (rsp.valid !== 1'b0) begin
                report_error("rsp.valid", rsp.valid, 0);
            end
        end else begin
            want = expected_rsp(update);
            checks++;
            if (busy !== 1'b0) begin
                report_error("busy", busy, 0);
            end
            if (rsp.valid !== want.valid) begin
                report_error("rsp.valid", rsp.valid, want.valid);
            end
            if (want.valid) begin
                if (rsp.hit !== want.hit) begin
                    report_error("hit", rsp.hit, want.hit);
                end
                if (want.hit && rsp.hit_way !== want.hit_way) begin
                    report_error("hit_way", rsp.hit_way, want.hit_way);
                end
                if (rsp.hit_vec !== want.hit_vec) begin
                    report_error("hit_vec", rsp.hit_vec, want.hit_vec);
                end
                if (rsp.valid_vec !== want.valid_vec) begin
                    report_error("valid_vec", rsp.valid_vec, want.valid_vec);
                end
                if (rsp.victim_way !== want.victim_way) begin
                    report_error("victim_way", rsp.victim_way, want.victim_way);
                end
                if (rsp.victim_tag !== want.victim_tag) begin
                    report_error("victim_tag", rsp.victim_tag, want.victim_tag);
                end
            end
            model_step(lookup, update, want);
        end
    end

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial begin
        int                      busy_cycles;
        l2_tag_pkg::upd_op_e     op;
        l2_tag_pkg::lookup_req_t lk;
        rst_n     <= 1'b0;
        lookup    <= NO_LOOKUP;
        update    <= NO_UPDATE;
        rnd_state = 32'he790_ae3a;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // Lookups and fills while the sweep runs are dropped
        busy_cycles = 0;
        for (int c = 0; c < `L2_SETS; c++) begin
            rnd_state = xorshift(rnd_state);
            lookup <= make_lookup(c[`L2_INDEX_BITS-1:0], rnd_state[`L2_TAG_BITS-1:0]);
            update <= make_update(l2_tag_pkg::UPD_FILL, 4'd0, rnd_state[1:0],
                                  rnd_state[`L2_TAG_BITS+1:2]);
            @(negedge clk);
            if (busy === 1'b1) begin
                busy_cycles++;
            end
            @(posedge clk);
        end
        lookup <= NO_LOOKUP;
        update <= NO_UPDATE;

        // Busy length after reset and empty sets afterwards
        @(negedge clk);
        while (busy === 1'b1 && busy_cycles <= 4 * `L2_SETS) begin
            busy_cycles++;
            @(negedge clk);
        end
        if (busy_cycles != `L2_SETS) begin
            $display("error at %0d ns: busy was high for %0d cycles, expected %0d",
                     $time, busy_cycles, `L2_SETS);
            errors++;
        end
        for (int s = 0; s < `L2_SETS; s++) begin
            rnd_state = xorshift(rnd_state);
            drive(make_lookup(s[`L2_INDEX_BITS-1:0], rnd_state[`L2_TAG_BITS-1:0]), NO_UPDATE);
        end
        finish_test("reset sweep");

        drive(NO_LOOKUP, make_update(l2_tag_pkg::UPD_FILL, 4'd3, 2'd2, TAG_BASE));
        drive(make_lookup(4'd3, TAG_BASE), NO_UPDATE);
        drive(make_lookup(4'd3, ~TAG_BASE), NO_UPDATE);
        finish_test("fill then lookup");

        for (int w = 0; w < 3; w++) begin
            drive(NO_LOOKUP, make_update(l2_tag_pkg::UPD_FILL, 4'd5, w[1:0], pool_tag(w[1:0])));
        end
        drive(make_lookup(4'd5, pool_tag(2'd1)), NO_UPDATE);
        drive(NO_LOOKUP, make_update(l2_tag_pkg::UPD_INVAL, 4'd5, 2'd1, '0));
        drive(make_lookup(4'd5, pool_tag(2'd1)), NO_UPDATE);
        finish_test("invalidate");

        // Update and lookup of set 6 in the same cycle
        drive(make_lookup(4'd6, ~TAG_BASE), make_update(l2_tag_pkg::UPD_FILL, 4'd6, 2'd0, ~TAG_BASE));
        drive(make_lookup(4'd6, ~TAG_BASE), make_update(l2_tag_pkg::UPD_INVAL, 4'd6, 2'd0, '0));
        drive(make_lookup(4'd6, ~TAG_BASE), make_update(l2_tag_pkg::UPD_FILL, 4'd6, 2'd3, ~TAG_BASE));
        finish_test("same-cycle update");

        for (int w = 0; w < `L2_WAYS; w++) begin
            drive(NO_LOOKUP, make_update(l2_tag_pkg::UPD_FILL, 4'd9, w[1:0], pool_tag(w[1:0])));
        end
        drive(make_lookup(4'd9, ~TAG_BASE), NO_UPDATE);
        drive(make_lookup(4'd9, pool_tag(2'd0)), NO_UPDATE);
        drive(make_lookup(4'd9, pool_tag(2'd2)), NO_UPDATE);
        drive(make_lookup(4'd9, ~TAG_BASE), NO_UPDATE);
        drive(make_lookup(4'd9, pool_tag(2'd1)), NO_UPDATE);
        drive(make_lookup(4'd9, ~TAG_BASE), NO_UPDATE);
        // Fill right behind a hit outranks that hit's touch
        drive(make_lookup(4'd9, pool_tag(2'd3)), NO_UPDATE);
        drive(make_lookup(4'd9, ~TAG_BASE), make_update(l2_tag_pkg::UPD_FILL, 4'd9, 2'd1, TAG_BASE));
        drive(make_lookup(4'd9, ~TAG_BASE), NO_UPDATE);
        finish_test("pseudo-LRU victim");

        for (int n = 0; n < RAND_OPS; n++) begin
            rnd_state = xorshift(rnd_state);
            lk        = NO_LOOKUP;
            if (rnd_state[1:0] != 2'b00) begin
                lk = make_lookup({2'b00, rnd_state[3:2]}, pool_tag(rnd_state[5:4]));
            end
            case (rnd_state[7:6])
                2'd1, 2'd3: op = l2_tag_pkg::UPD_FILL;
                2'd2:       op = l2_tag_pkg::UPD_INVAL;
                default:    op = l2_tag_pkg::UPD_NONE;
            endcase
            drive(lk, make_update(op, {2'b00, rnd_state[9:8]}, rnd_state[11:10],
                                  pool_tag(rnd_state[13:12])));
        end
        finish_test("random stream");

        $display("%0d tests, %0d failed, %0d response cycles checked, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Testbench failed");
        $finish;
    end

endmodule
